// ==== include/imuldiv_params.svh ====
/*
 * iterative divider parameters
 * operand width and the number of shift-subtract steps
 */

`ifndef IMULDIV_PARAMS_SVH
`define IMULDIV_PARAMS_SVH

// ---------------------------------------------------------------------------
// operand width
// ---------------------------------------------------------------------------

// dividend, divisor, quotient and remainder all share this width
`define IMULDIV_XLEN 32

// ---------------------------------------------------------------------------
// iteration count
// ---------------------------------------------------------------------------

// one restoring step per quotient bit, no early exit
`define IMULDIV_DIV_ITERS 32

`endif

// ==== design/imuldiv_pkg.sv ====
/*
 * divider types
 * request function encoding and control FSM states
 */

package imuldiv_pkg;

  // ---------------------------------------------------------------------------
  // request function
  // ---------------------------------------------------------------------------

  // selects two's complement or plain binary operands
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_t;

  // ---------------------------------------------------------------------------
  // control FSM
  // ---------------------------------------------------------------------------

  // idle accepts, calc runs the loop, done offers the response
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_t;

endpackage

// ==== design/int_div_dpath.sv ====
/*
 * iterative divider datapath
 * operand magnitudes, restoring shift-subtract step, sign correction
 */

`timescale 1ns/100ps

`include "imuldiv_params.svh"

module int_div_dpath import imuldiv_pkg::*; (
  input  logic                        clk,
  input  logic                        reset,

  // request payload
  input  div_fn_t                     divreq_msg_fn,
  input  logic [`IMULDIV_XLEN-1:0]    divreq_msg_a,
  input  logic [`IMULDIV_XLEN-1:0]    divreq_msg_b,

  // controls from the FSM
  input  logic                        a_en,
  input  logic                        b_en,
  input  logic                        a_mux_sel,
  input  logic                        sub_mux_sel,

  // status back to the FSM
  output logic                        diff_neg,

  // response payload
  output logic [2*`IMULDIV_XLEN-1:0]  divresp_msg_result
);

  localparam int XLEN = `IMULDIV_XLEN;
  // remainder, quotient and one borrow bit
  localparam int WIDE = 2*XLEN + 1;

  // ---------------------------------------------------------------------------
  // operand magnitudes
  // ---------------------------------------------------------------------------

  logic            req_signed;
  logic            a_in_neg;
  logic            b_in_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [WIDE-1:0] initial_a;
  logic [WIDE-1:0] initial_b;

  assign req_signed = (divreq_msg_fn == DIV_FN_SIGNED);

  // sign bits only count for the signed function
  assign a_in_neg = req_signed && divreq_msg_a[XLEN-1];
  assign b_in_neg = req_signed && divreq_msg_b[XLEN-1];

  // most negative value maps to 2**(XLEN-1), still fits unsigned
  assign a_mag = a_in_neg ? (~divreq_msg_a + 1'b1) : divreq_msg_a;
  assign b_mag = b_in_neg ? (~divreq_msg_b + 1'b1) : divreq_msg_b;

  // dividend sits in the low half, empty remainder above it
  assign initial_a = {{(XLEN+1){1'b0}}, a_mag};
  // divisor lined up with the remainder half
  assign initial_b = {1'b0, b_mag, {XLEN{1'b0}}};

  // ---------------------------------------------------------------------------
  // restoring step
  // ---------------------------------------------------------------------------

  logic [WIDE-1:0] a_reg;
  logic [WIDE-1:0] b_reg;
  logic [WIDE-1:0] a_shift;
  logic [WIDE-1:0] sub_out;
  logic [WIDE-1:0] sub_mux_out;
  logic [WIDE-1:0] a_mux_out;

  assign a_shift = a_reg << 1;
  assign sub_out = a_shift - b_reg;

  // borrow out of the trial subtraction
  assign diff_neg = sub_out[WIDE-1];

  // keep shifted value on borrow, else commit difference with quotient bit
  assign sub_mux_out = sub_mux_sel ? a_shift : {sub_out[WIDE-1:1], 1'b1};

  // initial load or step result
  assign a_mux_out = a_mux_sel ? sub_mux_out : initial_a;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= initial_b;
    end
  end

  // ---------------------------------------------------------------------------
  // request attributes for sign correction
  // ---------------------------------------------------------------------------

  div_fn_t fn_reg;
  logic    sign_a_reg;
  logic    sign_b_reg;

  // captured together with the divisor on the accepting edge
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg     <= DIV_FN_UNSIGNED;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (b_en) begin
      fn_reg     <= divreq_msg_fn;
      sign_a_reg <= divreq_msg_a[XLEN-1];
      sign_b_reg <= divreq_msg_b[XLEN-1];
    end
  end

  // ---------------------------------------------------------------------------
  // sign correction
  // ---------------------------------------------------------------------------

  logic            fn_signed;
  logic            quot_neg;
  logic            rem_neg;
  logic [XLEN-1:0] quot_mag;
  logic [XLEN-1:0] rem_mag;
  logic [XLEN-1:0] quot_out;
  logic [XLEN-1:0] rem_out;

  assign fn_signed = (fn_reg == DIV_FN_SIGNED);

  assign quot_mag = a_reg[XLEN-1:0];
  assign rem_mag  = a_reg[2*XLEN-1:XLEN];

  // quotient negative when operand signs differ
  assign quot_neg = fn_signed && (sign_a_reg ^ sign_b_reg);
  // remainder follows the dividend
  assign rem_neg  = fn_signed && sign_a_reg;

  assign quot_out = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign rem_out  = rem_neg  ? (~rem_mag + 1'b1)  : rem_mag;

  // remainder in the upper half, quotient in the lower
  assign divresp_msg_result = {rem_out, quot_out};

endmodule

// ==== design/int_div_ctrl.sv ====
/*
 * iterative divider control
 * FSM with step counter, valid/ready handshake and datapath enables
 */

`timescale 1ns/100ps

`include "imuldiv_params.svh"

module int_div_ctrl import imuldiv_pkg::*; (
  input  logic clk,
  input  logic reset,

  // handshake
  input  logic divreq_val,
  output logic divreq_rdy,
  output logic divresp_val,
  input  logic divresp_rdy,

  // datapath controls
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic sub_mux_sel,

  // borrow from the trial subtraction
  input  logic diff_neg
);

  // count value once every step has been committed
  localparam logic [5:0] ITER_LIMIT = 6'(`IMULDIV_DIV_ITERS);

  div_state_t state_reg;
  div_state_t state_next;
  logic [5:0] count_reg;
  logic       req_go;
  logic       resp_go;
  logic       steps_done;

  assign req_go     = divreq_val && divreq_rdy;
  assign resp_go    = divresp_val && divresp_rdy;
  assign steps_done = (count_reg == ITER_LIMIT);

  // ---------------------------------------------------------------------------
  // state and step counter
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= DIV_IDLE;
      count_reg <= '0;
    end else begin
      state_reg <= state_next;
      if (req_go) begin
        count_reg <= '0;
      end else if ((state_reg == DIV_CALC) && !steps_done) begin
        count_reg <= count_reg + 6'd1;
      end
    end
  end

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      DIV_IDLE: if (req_go) state_next = DIV_CALC;
      // one extra calc cycle after the last step before done
      DIV_CALC: if (steps_done) state_next = DIV_DONE;
      DIV_DONE: if (resp_go) state_next = DIV_IDLE;
      default:  state_next = DIV_IDLE;
    endcase
  end

  // ---------------------------------------------------------------------------
  // output decode
  // ---------------------------------------------------------------------------

  always_comb begin
    divreq_rdy  = 1'b0;
    divresp_val = 1'b0;
    a_en        = 1'b0;
    b_en        = 1'b0;
    a_mux_sel   = 1'b0;
    sub_mux_sel = 1'b0;
    case (state_reg)
      DIV_IDLE: begin
        divreq_rdy = 1'b1;
        // load both operand registers on the accepting edge
        a_en       = divreq_val;
        b_en       = divreq_val;
      end
      DIV_CALC: begin
        a_en        = !steps_done;
        a_mux_sel   = 1'b1;
        // borrow means restore, i.e. keep the shifted value
        sub_mux_sel = diff_neg;
      end
      DIV_DONE: begin
        // result held until the response transfers
        divresp_val = 1'b1;
      end
      default: begin
        divreq_rdy = 1'b0;
      end
    endcase
  end

endmodule

// ==== design/int_div_iterative.sv ====
/*
 * iterative integer divider top
 * joins the control FSM and the datapath
 */

`timescale 1ns/100ps

`include "imuldiv_params.svh"

module int_div_iterative import imuldiv_pkg::*; (
  input  logic                        clk,
  input  logic                        reset,

  // request
  input  div_fn_t                     divreq_msg_fn,
  input  logic [`IMULDIV_XLEN-1:0]    divreq_msg_a,
  input  logic [`IMULDIV_XLEN-1:0]    divreq_msg_b,
  input  logic                        divreq_val,
  output logic                        divreq_rdy,

  // response
  output logic [2*`IMULDIV_XLEN-1:0]  divresp_msg_result,
  output logic                        divresp_val,
  input  logic                        divresp_rdy
);

  // ctrl to dpath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  // dpath to ctrl
  logic diff_neg;

  int_div_ctrl ctrl (
    .clk         (clk),
    .reset       (reset),
    .divreq_val  (divreq_val),
    .divreq_rdy  (divreq_rdy),
    .divresp_val (divresp_val),
    .divresp_rdy (divresp_rdy),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .sub_mux_sel (sub_mux_sel),
    .diff_neg    (diff_neg)
  );

  int_div_dpath dpath (
    .clk                (clk),
    .reset              (reset),
    .divreq_msg_fn      (divreq_msg_fn),
    .divreq_msg_a       (divreq_msg_a),
    .divreq_msg_b       (divreq_msg_b),
    .a_en               (a_en),
    .b_en               (b_en),
    .a_mux_sel          (a_mux_sel),
    .sub_mux_sel        (sub_mux_sel),
    .diff_neg           (diff_neg),
    .divresp_msg_result (divresp_msg_result)
  );

endmodule

// ==== bench/int_div_checker.sv ====
/*
 * divider response checker
 * models each accepted request, checks latency, hold and result
 */

`timescale 1ns/100ps

`include "imuldiv_params.svh"

module int_div_checker import imuldiv_pkg::*; (
  input  logic                        clk,
  input  logic                        reset,
  input  div_fn_t                     divreq_msg_fn,
  input  logic [`IMULDIV_XLEN-1:0]    divreq_msg_a,
  input  logic [`IMULDIV_XLEN-1:0]    divreq_msg_b,
  input  logic                        divreq_val,
  input  logic                        divreq_rdy,
  input  logic [2*`IMULDIV_XLEN-1:0]  divresp_msg_result,
  input  logic                        divresp_val,
  input  logic                        divresp_rdy,
  // hand-computed value from the stimulus table, if any
  input  logic [2*`IMULDIV_XLEN-1:0]  ref_result,
  input  logic                        ref_given,
  output int                          test_count,
  output int                          pass_count,
  output int                          error_count
);

  localparam int XLEN    = `IMULDIV_XLEN;
  localparam int LATENCY = `IMULDIV_DIV_ITERS + 1;

  // restoring division on magnitudes, then signs
  function automatic logic [2*XLEN-1:0] expected_division(div_fn_t fn,
                                                          logic [XLEN-1:0] a,
                                                          logic [XLEN-1:0] b);
    logic            neg_a;
    logic            neg_b;
    logic [XLEN-1:0] mag_a;
    logic [XLEN-1:0] mag_b;
    logic [XLEN-1:0] quot;
    logic [XLEN-1:0] rem;
    neg_a = (fn == DIV_FN_SIGNED) && a[XLEN-1];
    neg_b = (fn == DIV_FN_SIGNED) && b[XLEN-1];
    mag_a = neg_a ? -a : a;
    mag_b = neg_b ? -b : b;
    // zero divisor: every trial subtraction succeeds
    if (mag_b == '0) begin
      quot = '1;
      rem  = mag_a;
    end else begin
      quot = mag_a / mag_b;
      rem  = mag_a % mag_b;
    end
    if (neg_a ^ neg_b) quot = -quot;
    if (neg_a) rem = -rem;
    return {rem, quot};
  endfunction

  logic [2*XLEN-1:0] exp_q[$];
  logic [2*XLEN-1:0] ref_q[$];
  logic              given_q[$];
  logic [2*XLEN:0]   req_q[$];
  int                accept_q[$];

  int                cycle;
  logic              reset_checked;
  logic              prev_val;
  logic              prev_rdy;
  logic [2*XLEN-1:0] prev_result;

  initial begin
    test_count    = 0;
    pass_count    = 0;
    error_count   = 0;
    cycle         = 0;
    reset_checked = 1'b0;
    prev_val      = 1'b0;
    prev_rdy      = 1'b0;
    prev_result   = '0;
  end

  // ---------------------------------------------------------------------------
  // sampled mid-cycle, inputs only move just after the rising edge
  // ---------------------------------------------------------------------------

  always @(negedge clk) begin
    logic [2*XLEN-1:0] exp_val;
    logic [2*XLEN-1:0] ref_val;
    logic              given;
    logic [2*XLEN:0]   req;
    logic              bad;
    if (!reset) begin
      cycle++;
      // idle state right after reset
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (divreq_rdy !== 1'b1 || divresp_val !== 1'b0) begin
          $display("after reset the divider is not idle: divreq_rdy %b, divresp_val %b",
                   divreq_rdy, divresp_val);
          error_count++;
        end
      end
      // request transfers on the coming edge
      if (divreq_val && divreq_rdy) begin
        exp_q.push_back(expected_division(divreq_msg_fn, divreq_msg_a, divreq_msg_b));
        ref_q.push_back(ref_result);
        given_q.push_back(ref_given);
        req_q.push_back({divreq_msg_fn, divreq_msg_a, divreq_msg_b});
        // count of the half cycle just after the accepting edge
        accept_q.push_back(cycle + 1);
      end
      // latency from accepting edge to valid
      if (divresp_val && !prev_val) begin
        if (accept_q.size() == 0) begin
          $display("response valid rose at %0d ns with no request accepted", $time);
          error_count++;
        end else if (cycle - accept_q[0] != LATENCY) begin
          $display("response valid rose %0d cycles after the request, not %0d",
                   cycle - accept_q[0], LATENCY);
          error_count++;
        end
        if (accept_q.size() != 0) void'(accept_q.pop_front());
      end
      // back-pressure: valid and result held
      if (prev_val && !prev_rdy) begin
        if (!divresp_val) begin
          $display("response valid dropped at %0d ns before the transfer", $time);
          error_count++;
        end else if (divresp_msg_result !== prev_result) begin
          $display("** Error at %0d ns: divresp_msg_result = %h, held value %h",
                   $time, divresp_msg_result, prev_result);
          error_count++;
        end
      end
      if (divresp_val && divreq_rdy) begin
        $display("request ready high at %0d ns while a response is pending", $time);
        error_count++;
      end
      // response transfer on the coming edge
      if (divresp_val && divresp_rdy) begin
        if (exp_q.size() == 0) begin
          $display("response transferred at %0d ns with no request outstanding", $time);
          error_count++;
        end else begin
          exp_val = exp_q.pop_front();
          ref_val = ref_q.pop_front();
          given   = given_q.pop_front();
          req     = req_q.pop_front();
          bad     = 1'b0;
          test_count++;
          if (divresp_msg_result !== exp_val) begin
            $display("** Error at %0d ns: divresp_msg_result = %h, expected %h",
                     $time, divresp_msg_result, exp_val);
            bad = 1'b1;
          end
          if (given && divresp_msg_result !== ref_val) begin
            $display("** Error at %0d ns: divresp_msg_result = %h, table value %h",
                     $time, divresp_msg_result, ref_val);
            bad = 1'b1;
          end
          if (bad) begin
            error_count++;
          end else begin
            pass_count++;
            $display("test %0d passed: fn %0d a %h b %h result %h", test_count,
                     req[2*XLEN], req[2*XLEN-1:XLEN], req[XLEN-1:0], divresp_msg_result);
          end
        end
      end
      prev_val    = divresp_val;
      prev_rdy    = divresp_rdy;
      prev_result = divresp_msg_result;
    end
  end

endmodule

// ==== bench/int_div_tb.sv ====
/*
 * iterative divider testbench
 * table and random vectors through the valid/ready ports
 */

`timescale 1ns/100ps

`include "imuldiv_params.svh"

module int_div_tb import imuldiv_pkg::*; ();

  localparam int XLEN       = `IMULDIV_XLEN;
  localparam int NUM_TABLE  = 14;
  localparam int NUM_RANDOM = 16;
  localparam int NUM_VECTORS = NUM_TABLE + NUM_RANDOM;
  localparam int MAX_STALL  = 5;
  localparam int TIMEOUT_CYCLES =
    NUM_VECTORS * (`IMULDIV_DIV_ITERS + 1 + MAX_STALL + 4) + 20;

  logic              clk;
  logic              reset;
  div_fn_t           divreq_msg_fn;
  logic [XLEN-1:0]   divreq_msg_a;
  logic [XLEN-1:0]   divreq_msg_b;
  logic              divreq_val;
  logic              divreq_rdy;
  logic [2*XLEN-1:0] divresp_msg_result;
  logic              divresp_val;
  logic              divresp_rdy;
  logic [2*XLEN-1:0] ref_result;
  logic              ref_given;
  int                test_count;
  int                pass_count;
  int                error_count;
  int                cycle_count;

  // fn | dividend | divisor | stall | remainder:quotient
  logic [132:0] vec_table [0:NUM_TABLE-1];

  int_div_iterative uut (.*);

  int_div_checker chk (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit
  initial cycle_count = 0;
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic fill_table();
    // unsigned ordinary and edge values
    vec_table[0]  = {DIV_FN_UNSIGNED, 32'd100, 32'd7, 4'd0, 64'h00000002_0000000e};
    vec_table[1]  = {DIV_FN_UNSIGNED, 32'hffffffff, 32'd1, 4'd2, 64'h00000000_ffffffff};
    vec_table[2]  = {DIV_FN_UNSIGNED, 32'd5, 32'hffffffff, 4'd0, 64'h00000005_00000000};
    vec_table[3]  = {DIV_FN_UNSIGNED, 32'h12345678, 32'h12345678, 4'd1, 64'h0_00000001};
    vec_table[4]  = {DIV_FN_UNSIGNED, 32'hffffffff, 32'h10, 4'd0, 64'h0000000f_0fffffff};
    // signed, all four sign pairs
    vec_table[5]  = {DIV_FN_SIGNED, 32'd7, 32'd2, 4'd3, 64'h00000001_00000003};
    vec_table[6]  = {DIV_FN_SIGNED, 32'hfffffff9, 32'd2, 4'd0, 64'hffffffff_fffffffd};
    vec_table[7]  = {DIV_FN_SIGNED, 32'd7, 32'hfffffffe, 4'd1, 64'h00000001_fffffffd};
    vec_table[8]  = {DIV_FN_SIGNED, 32'hfffffff9, 32'hfffffffe, 4'd0, 64'hffffffff_00000003};
    vec_table[9]  = {DIV_FN_SIGNED, 32'h80000000, 32'hffffffff, 4'd5, 64'h00000000_80000000};
    vec_table[10] = {DIV_FN_SIGNED, 32'hffffff9c, 32'd7, 4'd4, 64'hfffffffe_fffffff2};
    // zero divisor
    vec_table[11] = {DIV_FN_UNSIGNED, 32'h1234, 32'd0, 4'd0, 64'h00001234_ffffffff};
    vec_table[12] = {DIV_FN_SIGNED, 32'hfffffffb, 32'd0, 4'd2, 64'hfffffffb_00000001};
    vec_table[13] = {DIV_FN_SIGNED, 32'd9, 32'd0, 4'd0, 64'h00000009_ffffffff};
  endtask

  // inputs move 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic run_vector(input div_fn_t fn, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input int stall,
                            input logic [2*XLEN-1:0] res, input logic given);
    while (!divreq_rdy) next_cycle();
    divreq_msg_fn = fn;
    divreq_msg_a  = a;
    divreq_msg_b  = b;
    ref_result    = res;
    ref_given     = given;
    divreq_val    = 1'b1;
    next_cycle();
    divreq_val = 1'b0;
    // back-pressure for the stall count, then take the response
    while (!divresp_val) next_cycle();
    repeat (stall) next_cycle();
    divresp_rdy = 1'b1;
    next_cycle();
    divresp_rdy = 1'b0;
  endtask

  initial begin
    logic [132:0]    entry;
    logic [XLEN-1:0] rnd_sel;
    logic [XLEN-1:0] rnd_a;
    logic [XLEN-1:0] rnd_b;
    int              seed;
    seed          = 32'hd0e8f279;
    reset         = 1'b1;
    divreq_msg_fn = DIV_FN_UNSIGNED;
    divreq_msg_a  = '0;
    divreq_msg_b  = '0;
    divreq_val    = 1'b0;
    divresp_rdy   = 1'b0;
    ref_result    = '0;
    ref_given     = 1'b0;
    fill_table();
    repeat (2) @(posedge clk);
    #2 reset = 1'b0;
    for (int i = 0; i < NUM_TABLE; i++) begin
      entry = vec_table[i];
      run_vector(div_fn_t'(entry[132]), entry[131:100], entry[99:68],
                 int'(entry[67:64]), entry[63:0], 1'b1);
    end
    // random operands, divisor scaled down for varied quotients
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd_sel = $random(seed);
      rnd_a   = $random(seed);
      rnd_b   = $random(seed);
      rnd_b   = rnd_b >> rnd_sel[4:0];
      run_vector(div_fn_t'(rnd_sel[8]), rnd_a, rnd_b, int'(rnd_sel[10:9]), '0, 1'b0);
    end
    repeat (2) next_cycle();
    if (test_count != NUM_VECTORS) begin
      $display("only %0d of %0d responses were seen", test_count, NUM_VECTORS);
    end
    $display("tests %0d, passed %0d, errors %0d", test_count, pass_count, error_count);
    if (error_count == 0 && test_count == NUM_VECTORS) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
design/imuldiv_pkg.sv
design/int_div_dpath.sv
design/int_div_ctrl.sv
design/int_div_iterative.sv
bench/int_div_checker.sv
bench/int_div_tb.sv

// ==== Bender.yml ====
package:
  name: int_div_iterative

export_include_dirs:
  - include

sources:
  - files:
      - design/imuldiv_pkg.sv
      - design/int_div_dpath.sv
      - design/int_div_ctrl.sv
      - design/int_div_iterative.sv
  - target: simulation
    files:
      - bench/int_div_checker.sv
      - bench/int_div_tb.sv
